//--- sources.f
+incdir+sim
logic/cpld_pkg.sv
logic/ifc_slave.sv
logic/board_io.sv
logic/access_counter.sv
logic/reg_bank.sv
logic/cpld_top.sv
sim/tb_cpld_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_cpld_top -o tb_cpld_top

./obj_dir/tb_cpld_top > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- sim/tb_ifc_tasks.svh
`ifndef TB_IFC_TASKS_SVH
`define TB_IFC_TASKS_SVH

// ********************
// IFC bus cycles, all phases start on a falling clock edge
localparam int PHASE_CLKS = 8;      // master holds each phase this long
localparam int IDLE_CLKS  = 2;

function automatic logic [7:0] reverse_bits8(input logic [7:0] v);
    logic [7:0] r;
    for (int k = 0; k < 8; k++) begin
        r[k] = v[7 - k];
    end
    return r;
endfunction

function automatic logic [15:0] reverse_bits16(input logic [15:0] v);
    logic [15:0] r;
    for (int k = 0; k < 16; k++) begin
        r[k] = v[15 - k];
    end
    return r;
endfunction

// address phase, CS stays low for the data phase that follows
task automatic bus_addr_phase(input logic [7:0] addr);
    @(negedge high_cpld_clk);
    ifc_cs   = 1'b0;
    ifc_addr = reverse_bits8(addr);     // bus bit i carries reg bit 7-i
    ifc_avd  = 1'b0;
    repeat (PHASE_CLKS) @(negedge high_cpld_clk);
    ifc_avd  = 1'b1;
endtask

task automatic bus_read(input logic [7:0] addr, output logic [15:0] data,
                        output logic oe_seen);
    bus_addr_phase(addr);
    ifc_oe_b = 1'b0;
    repeat (PHASE_CLKS) @(negedge high_cpld_clk);
    data     = reverse_bits16(ifc_ad_out);  // sampled before OE goes back up
    oe_seen  = ifc_ad_oe;
    ifc_oe_b = 1'b1;
    ifc_cs   = 1'b1;
    repeat (IDLE_CLKS) @(negedge high_cpld_clk);
endtask

task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    bus_addr_phase(addr);
    ifc_ad_in = reverse_bits16(data);
    ifc_we_b  = 1'b0;
    repeat (PHASE_CLKS) @(negedge high_cpld_clk);
    ifc_we_b  = 1'b1;
    ifc_cs    = 1'b1;
    repeat (IDLE_CLKS) @(negedge high_cpld_clk);
endtask

// OE low while CS stays high, another device owns the bus
task automatic unselected_oe_pulse(output logic oe_seen);
    @(negedge high_cpld_clk);
    ifc_cs   = 1'b1;
    ifc_oe_b = 1'b0;
    repeat (PHASE_CLKS) @(negedge high_cpld_clk);
    oe_seen  = ifc_ad_oe;
    ifc_oe_b = 1'b1;
    repeat (IDLE_CLKS) @(negedge high_cpld_clk);
endtask

`endif

//--- sim/tb_cpld_top.sv
`default_nettype none

module tb_cpld_top;

    localparam int OP_WRITE     = 0;
    localparam int OP_READ      = 1;
    localparam int OP_SET_IO    = 2;
    localparam int OP_SET_VDROP = 3;
    localparam int OP_OE_UNSEL  = 4;

    logic        high_cpld_clk = 1'b0;
    logic        rst_n;
    logic [15:0] ifc_ad_in;
    logic [7:0]  ifc_addr;
    logic        ifc_cs;
    logic        ifc_we_b;
    logic        ifc_oe_b;
    logic        ifc_avd;
    logic        voltage_drop;
    logic [15:0] io_in;
    logic [15:0] ifc_ad_out;
    logic        ifc_ad_oe;
    logic        irq;
    logic [15:0] io_out;

    integer      seed = 32'h2a31d757;
    int          errors = 0;
    int          checks = 0;
    logic        table_ready = 1'b0;

    // stimulus table, one entry per step
    string       step_name [$];
    int          step_op [$];
    logic [7:0]  step_addr [$];
    logic [15:0] step_data [$];
    logic [15:0] step_exp [$];

    // model of the writable registers
    logic [15:0] ctrl_shadow [18:26];
    logic [15:0] test_shadow;

    always #20 high_cpld_clk = ~high_cpld_clk;

    cpld_top cpld_top_i (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .ifc_ad_in     (ifc_ad_in),
        .ifc_addr      (ifc_addr),
        .ifc_cs        (ifc_cs),
        .ifc_we_b      (ifc_we_b),
        .ifc_oe_b      (ifc_oe_b),
        .ifc_avd       (ifc_avd),
        .voltage_drop  (voltage_drop),
        .io_in         (io_in),
        .ifc_ad_out    (ifc_ad_out),
        .ifc_ad_oe     (ifc_ad_oe),
        .irq           (irq),
        .io_out        (io_out)
    );

    `include "tb_ifc_tasks.svh"

    // ********************
    // expected values
    function automatic logic [15:0] pins_expect();
        logic [15:0] p;
        logic [7:0]  h;
        h       = ctrl_shadow[26][7:0];
        p[15:13] = 3'b011;
        p[12]   = ctrl_shadow[21][0];
        p[11]   = ctrl_shadow[25][0];
        p[10]   = ctrl_shadow[21][1];
        p[9]    = ctrl_shadow[24][0];
        p[8]    = ctrl_shadow[21][2];
        p[7]    = ctrl_shadow[23][0] & h[7];
        p[6]    = ctrl_shadow[21][3] & h[6];
        p[5]    = ctrl_shadow[22][0] & h[5];
        p[4]    = ctrl_shadow[21][4] & h[4];
        p[3]    = ctrl_shadow[19][1] & h[3];
        p[2]    = ctrl_shadow[20][0] & h[2];
        p[1]    = ctrl_shadow[19][0] & h[1];
        p[0]    = ctrl_shadow[18][0] & h[0];
        return p;
    endfunction

    // connector input bits as they show up at addresses 2 to 17
    function automatic logic [15:0] input_field(input logic [7:0] addr, input logic [15:0] io);
        logic [15:0] f;
        f = 16'h0;
        case (addr)
            8'd2:  f[1:0] = {io[0], io[2]};
            8'd3:  f[3:0] = {io[7], io[5], io[3], io[1]};
            8'd4:  f[1:0] = {io[6], io[4]};
            8'd5:  f[0]   = io[8];
            8'd6:  f[0]   = io[9];
            8'd7:  f[1:0] = {io[12], io[10]};
            8'd8:  f[0]   = io[11];
            8'd9:  f[0]   = io[15];
            8'd10: f[0]   = io[13];
            8'd11: f[0]   = io[14];
            8'd12: f[0]   = io[0];
            8'd13: f[0]   = io[1];
            8'd14: f[1:0] = {io[4], io[2]};
            8'd15: f[0]   = io[5];
            8'd16: f[1:0] = {io[6], io[4]};
            8'd17: f[7:0] = io[14:7];
            default: f = 16'h0;
        endcase
        return f;
    endfunction

    // ********************
    // table building
    task automatic add_step(input string name, input int op, input logic [7:0] addr,
                            input logic [15:0] data, input logic [15:0] exp);
        step_name.push_back(name);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_data.push_back(data);
        step_exp.push_back(exp);
    endtask

    task automatic add_read(input string name, input logic [7:0] addr, input logic [15:0] exp);
        add_step(name, OP_READ, addr, 16'h0, exp);
    endtask

    // expected value of a write is the pin state afterwards
    task automatic add_write(input string name, input logic [7:0] addr, input logic [15:0] d);
        case (addr)
            8'd19: ctrl_shadow[19] = (d[1:0] == 2'b11) ? 16'h0 : 16'h3;
            8'd21: ctrl_shadow[21] = {11'h0, d[4:0]};
            8'd26: ctrl_shadow[26] = {8'h0, d[7:0]};
            8'd34: test_shadow = d;
            default: begin
                if (addr >= 8'd18 && addr <= 8'd25) ctrl_shadow[addr] = {15'h0, d[0]};
            end
        endcase
        add_step(name, OP_WRITE, addr, d, pins_expect());
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [15:0] io_val;
        for (logic [7:0] a = 8'd18; a <= 8'd26; a++) begin
            ctrl_shadow[a] = 16'h1;
        end
        ctrl_shadow[19] = 16'h3;
        ctrl_shadow[21] = 16'h1f;
        ctrl_shadow[26] = 16'hff;
        test_shadow     = 16'h1234;

        add_read("version", 8'd0, 16'h2134);
        add_read("test_reset", 8'd34, 16'h1234);
        for (logic [7:0] a = 8'd18; a <= 8'd26; a++) begin
            rnd = $random(seed);
            add_write($sformatf("wr_%0d", a), a, rnd[15:0]);
            add_read($sformatf("rd_%0d", a), a, ctrl_shadow[a]);
        end
        rnd = $random(seed);
        add_write("wr_test", 8'd34, rnd[15:0]);
        add_read("rd_test", 8'd34, test_shadow);
        add_write("crh_wr_3", 8'd19, 16'h3);
        add_read("crh_rd_3", 8'd19, 16'h0);
        add_write("crh_wr_1", 8'd19, 16'h1);
        add_read("crh_rd_1", 8'd19, 16'h3);
        add_read("unmapped_40", 8'd40, 16'h0);

        repeat (2) begin
            rnd    = $random(seed);
            io_val = rnd[15:0];
            add_step("set_io", OP_SET_IO, 8'd0, io_val, 16'h0);
            for (logic [7:0] a = 8'd2; a <= 8'd17; a++) begin
                add_read($sformatf("in_%0d", a), a, input_field(a, io_val));
            end
        end

        add_step("vdrop_rise", OP_SET_VDROP, 8'd0, 16'h1, 16'h1);
        add_read("vin_fall_set", 8'd28, 16'h1);
        add_step("vdrop_fall", OP_SET_VDROP, 8'd0, 16'h0, 16'h0);
        add_read("vin_fall_clear", 8'd28, 16'h0);

        // write counting, the mode write sees the old mode 0
        add_write("mode_wr_count", 8'd29, 16'h1);
        repeat (3) begin
            rnd = $random(seed);
            add_write("cnt_wr", 8'd34, rnd[15:0]);
        end
        add_read("wr_cnt_b0", 8'd30, 16'h3);
        add_read("wr_cnt_b1", 8'd31, 16'h0);
        add_read("wr_cnt_b2", 8'd32, 16'h0);
        add_read("wr_cnt_b3", 8'd33, 16'h0);
        // read counting, rdata holds the count from before its own read
        add_write("mode_rd_count", 8'd29, 16'h5);
        add_read("cnt_rd_1", 8'd34, test_shadow);
        add_read("cnt_rd_2", 8'd34, test_shadow);
        // an OE pulse without CS is no read and is not counted
        add_step("oe_no_cs", OP_OE_UNSEL, 8'd0, 16'h0, 16'h0);
        add_read("rd_cnt_b0", 8'd30, 16'h2);
        add_read("rd_cnt_b0_again", 8'd30, 16'h3);
        // clear both counters
        add_write("mode_clear", 8'd29, 16'h2);
        rnd = $random(seed);
        add_write("clear_by_wr", 8'd34, rnd[15:0]);
        add_read("wr_cnt_cleared", 8'd30, 16'h0);
        add_write("mode_rd_again", 8'd29, 16'h5);
        add_read("rd_cnt_cleared", 8'd30, 16'h0);
    endtask

    // ********************
    // checking
    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        errors++;
        $display("FAIL %s expected %h actual %h", name, exp, act);
    endtask

    task automatic run_step(input int i);
        logic [15:0] got;
        logic        oe_seen;
        case (step_op[i])
            OP_WRITE: begin
                bus_write(step_addr[i], step_data[i]);
                checks++;
                if (io_out !== step_exp[i]) report_mismatch(step_name[i], step_exp[i], io_out);
            end
            OP_READ: begin
                bus_read(step_addr[i], got, oe_seen);
                checks++;
                if (oe_seen !== 1'b1) begin
                    errors++;
                    $display("%s: DUT did not enable the data bus during the read", step_name[i]);
                end
                if (got !== step_exp[i]) report_mismatch(step_name[i], step_exp[i], got);
            end
            OP_SET_IO: begin
                @(negedge high_cpld_clk);
                io_in = step_data[i];
                @(negedge high_cpld_clk);
            end
            OP_OE_UNSEL: begin
                unselected_oe_pulse(oe_seen);
                checks++;
                if (oe_seen !== 1'b0) begin
                    errors++;
                    $display("%s: DUT drove the data bus without chip select", step_name[i]);
                end
            end
            default: begin
                @(negedge high_cpld_clk);
                voltage_drop = step_data[i][0];
                repeat (2) @(negedge high_cpld_clk);
                checks++;
                if (irq !== step_exp[i][0]) begin
                    report_mismatch(step_name[i], step_exp[i], {15'h0, irq});
                end
            end
        endcase
    endtask

    // data bus must stay released while CS is high
    always @(posedge high_cpld_clk) begin
        if (rst_n === 1'b1 && ifc_cs === 1'b1 && ifc_ad_oe !== 1'b0) begin
            errors++;
            $display("data bus enabled while chip select is high at %0t", $time);
        end
    end

    initial begin
        rst_n        = 1'b0;
        ifc_ad_in    = 16'h0;
        ifc_addr     = 8'h0;
        ifc_cs       = 1'b1;
        ifc_we_b     = 1'b1;
        ifc_oe_b     = 1'b1;
        ifc_avd      = 1'b1;
        voltage_drop = 1'b0;
        io_in        = 16'h0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(negedge high_cpld_clk);
        // values held by reset itself
        checks += 2;
        if (io_out !== 16'h7fff) report_mismatch("reset_io_out", 16'h7fff, io_out);
        if (irq !== 1'b0) report_mismatch("reset_irq", 16'h0, {15'h0, irq});
        rst_n = 1'b1;
        @(negedge high_cpld_clk);
        for (int i = 0; i < step_name.size(); i++) begin
            run_step(i);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog, table length x 40 clocks x 40 time units
    initial begin
        wait (table_ready);
        #(step_name.size() * 1600);
        $display("watchdog expired before the stimulus table completed");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/cpld_top.sv
`default_nettype none

module cpld_top (
    input  wire                     high_cpld_clk,
    input  wire                     rst_n,
    input  wire cpld_pkg::data_t    ifc_ad_in,
    input  wire cpld_pkg::addr_t    ifc_addr,
    input  wire                     ifc_cs,
    input  wire                     ifc_we_b,
    input  wire                     ifc_oe_b,
    input  wire                     ifc_avd,
    input  wire                     voltage_drop,
    input  wire [15:0]              io_in,
    output cpld_pkg::data_t         ifc_ad_out,
    output logic                    ifc_ad_oe,
    output logic                    irq,
    output logic [15:0]             io_out
);

    cpld_pkg::bus_req_t   bus_req;
    cpld_pkg::data_t      rdata;
    cpld_pkg::io_status_t io_status;
    cpld_pkg::ctrl_regs_t ctrl;
    cpld_pkg::cnt_mode_t  cnt_mode;
    cpld_pkg::cnt_t       cnt;
    logic                 vin_fall;

    // ********************
    // local bus slave
    ifc_slave ifc_slave_i (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .ifc_ad_in     (ifc_ad_in),
        .ifc_addr      (ifc_addr),
        .ifc_cs        (ifc_cs),
        .ifc_we_b      (ifc_we_b),
        .ifc_oe_b      (ifc_oe_b),
        .ifc_avd       (ifc_avd),
        .rdata         (rdata),
        .bus_req       (bus_req),
        .ifc_ad_out    (ifc_ad_out),
        .ifc_ad_oe     (ifc_ad_oe)
    );

    // ********************
    // registers and board pins
    reg_bank reg_bank_i (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .bus_req       (bus_req),
        .io_status     (io_status),
        .vin_fall      (vin_fall),
        .cnt           (cnt),
        .ctrl          (ctrl),
        .cnt_mode      (cnt_mode),
        .rdata         (rdata)
    );

    board_io board_io_i (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .io_in         (io_in),
        .voltage_drop  (voltage_drop),
        .ctrl          (ctrl),
        .io_status     (io_status),
        .vin_fall      (vin_fall),
        .irq           (irq),
        .io_out        (io_out)
    );

    access_counter access_counter_i (
        .high_cpld_clk (high_cpld_clk),
        .rst_n         (rst_n),
        .bus_req       (bus_req),
        .cnt_mode      (cnt_mode),
        .cnt           (cnt)
    );

endmodule

`default_nettype wire

//--- logic/reg_bank.sv
`default_nettype none

module reg_bank (
    input  wire                         high_cpld_clk,
    input  wire                         rst_n,
    input  wire cpld_pkg::bus_req_t     bus_req,
    input  wire cpld_pkg::io_status_t   io_status,
    input  wire                         vin_fall,
    input  wire cpld_pkg::cnt_t         cnt,
    output cpld_pkg::ctrl_regs_t        ctrl,
    output cpld_pkg::cnt_mode_t         cnt_mode,
    output cpld_pkg::data_t             rdata
);

    cpld_pkg::data_t test_q;
    cpld_pkg::data_t wdata;
    cpld_pkg::data_t rd_mux;

    assign wdata = bus_req.wdata;

    // ********************
    // write decode
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl     <= '1;     // outputs come up inactive high
            cnt_mode <= '0;
            test_q   <= cpld_pkg::TEST_RESET;
        end else if (bus_req.wr) begin
            case (bus_req.addr)
                cpld_pkg::ADDR_PNDT_SVON: ctrl.pndt_svon <= wdata[0];
                cpld_pkg::ADDR_CRH: begin
                    // 11 drops the safety loop, anything else closes it
                    ctrl.crh <= (wdata[1:0] == 2'b11) ? 2'b00 : 2'b11;
                end
                cpld_pkg::ADDR_OVRUN_CLR: ctrl.ovrun_clr <= wdata[0];
                cpld_pkg::ADDR_EXT_DISP:  ctrl.ext_disp  <= wdata[4:0];
                cpld_pkg::ADDR_RB_RDY:    ctrl.rb_rdy    <= wdata[0];
                cpld_pkg::ADDR_RB_ERR:    ctrl.rb_err    <= wdata[0];
                cpld_pkg::ADDR_SVO:       ctrl.svo       <= wdata[0];
                cpld_pkg::ADDR_SELF_SON:  ctrl.self_son  <= wdata[0];
                cpld_pkg::ADDR_HAND_OUT:  ctrl.hand_out  <= wdata[7:0];
                cpld_pkg::ADDR_CNT_MODE:  cnt_mode       <= wdata[2:0];
                cpld_pkg::ADDR_TEST:      test_q         <= wdata;
                default: ;      // read-only or unmapped
            endcase
        end
    end

    // ********************
    // read mux
    always_comb begin
        rd_mux = '0;
        case (bus_req.addr)
            cpld_pkg::ADDR_VERSION:     rd_mux        = cpld_pkg::CPLD_VERSION;
            // sampled inputs
            cpld_pkg::ADDR_CMODE_SEL:   rd_mux[1:0]   = io_status.cmode_sel;
            cpld_pkg::ADDR_EMS:         rd_mux[3:0]   = io_status.ems;
            cpld_pkg::ADDR_TMP_MON:     rd_mux[1:0]   = io_status.tmp_mon;
            cpld_pkg::ADDR_ACKM_MON:    rd_mux[0]     = io_status.ackm_mon;
            cpld_pkg::ADDR_SR_ERR:      rd_mux[0]     = io_status.sr_err;
            cpld_pkg::ADDR_PMODE_SEL:   rd_mux[1:0]   = io_status.pmode_sel;
            cpld_pkg::ADDR_EN12_PNDT:   rd_mux[0]     = io_status.en12_pndt;
            cpld_pkg::ADDR_EQ_DOOR2_B:  rd_mux[0]     = io_status.eq_door2_b;
            cpld_pkg::ADDR_ACPWR_MON:   rd_mux[0]     = io_status.acpwr_mon;
            cpld_pkg::ADDR_RIO_RDY:     rd_mux[0]     = io_status.rio_rdy;
            cpld_pkg::ADDR_EQ_SVON_B:   rd_mux[0]     = io_status.eq_svon_b;
            cpld_pkg::ADDR_EQ_REMOTE_B: rd_mux[0]     = io_status.eq_remote_b;
            cpld_pkg::ADDR_SAF_EMS6:    rd_mux[1:0]   = io_status.saf_ems6;
            cpld_pkg::ADDR_EMS12_PNDT:  rd_mux[0]     = io_status.ems12_pndt;
            cpld_pkg::ADDR_SAF_EMS3:    rd_mux[1:0]   = io_status.saf_ems3;
            cpld_pkg::ADDR_HAND_IN:     rd_mux[7:0]   = io_status.hand_in;
            // control registers
            cpld_pkg::ADDR_PNDT_SVON:   rd_mux[0]     = ctrl.pndt_svon;
            cpld_pkg::ADDR_CRH:         rd_mux[1:0]   = ctrl.crh;
            cpld_pkg::ADDR_OVRUN_CLR:   rd_mux[0]     = ctrl.ovrun_clr;
            cpld_pkg::ADDR_EXT_DISP:    rd_mux[4:0]   = ctrl.ext_disp;
            cpld_pkg::ADDR_RB_RDY:      rd_mux[0]     = ctrl.rb_rdy;
            cpld_pkg::ADDR_RB_ERR:      rd_mux[0]     = ctrl.rb_err;
            cpld_pkg::ADDR_SVO:         rd_mux[0]     = ctrl.svo;
            cpld_pkg::ADDR_SELF_SON:    rd_mux[0]     = ctrl.self_son;
            cpld_pkg::ADDR_HAND_OUT:    rd_mux[7:0]   = ctrl.hand_out;
            // status and counters
            cpld_pkg::ADDR_VIN_FALL:    rd_mux[0]     = vin_fall;
            cpld_pkg::ADDR_CNT_MODE:    rd_mux[2:0]   = cnt_mode;
            cpld_pkg::ADDR_CNT_B0:      rd_mux[7:0]   = cnt[7:0];
            cpld_pkg::ADDR_CNT_B1:      rd_mux[7:0]   = cnt[15:8];
            cpld_pkg::ADDR_CNT_B2:      rd_mux[7:0]   = cnt[23:16];
            cpld_pkg::ADDR_CNT_B3:      rd_mux[7:0]   = cnt[31:24];
            cpld_pkg::ADDR_TEST:        rd_mux        = test_q;
            default:                    rd_mux        = '0;
        endcase
    end

    // read data held until the next rd strobe
    always_ff @(posedge high_cpld_clk) begin
        if (bus_req.rd) begin
            rdata <= rd_mux;
        end
    end

    // safety loop pair must always switch together
    a_crh_pair : assert property (@(posedge high_cpld_clk) disable iff (!rst_n)
        ctrl.crh[1] == ctrl.crh[0]);

endmodule

`default_nettype wire

//--- logic/access_counter.sv
`default_nettype none

module access_counter (
    input  wire                     high_cpld_clk,
    input  wire                     rst_n,
    input  wire cpld_pkg::bus_req_t bus_req,
    input  wire cpld_pkg::cnt_mode_t cnt_mode,
    output cpld_pkg::cnt_t          cnt
);

    cpld_pkg::cnt_t rd_cnt;
    cpld_pkg::cnt_t wr_cnt;

    // mode is taken as it was before the strobe
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else begin
            if (bus_req.rd) begin
                if (cnt_mode.clear) begin
                    rd_cnt <= '0;
                end else if (cnt_mode.enable && cnt_mode.sel_read) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
            end
            if (bus_req.wr) begin
                if (cnt_mode.clear) begin
                    wr_cnt <= '0;
                end else if (cnt_mode.enable && !cnt_mode.sel_read) begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
        end
    end

    assign cnt = cnt_mode.sel_read ? rd_cnt : wr_cnt;

    // one bus event per cycle from ifc_slave
    a_one_counter : assert property (@(posedge high_cpld_clk) disable iff (!rst_n)
        !($changed(rd_cnt) && $changed(wr_cnt)));

endmodule

`default_nettype wire

//--- logic/board_io.sv
`default_nettype none

module board_io (
    input  wire                         high_cpld_clk,
    input  wire                         rst_n,
    input  wire [15:0]                  io_in,
    input  wire                         voltage_drop,
    input  wire cpld_pkg::ctrl_regs_t   ctrl,
    output cpld_pkg::io_status_t        io_status,
    output logic                        vin_fall,
    output logic                        irq,
    output logic [15:0]                 io_out
);

    // ********************
    // input sampling
    // both connector boards share io_in, so fields overlap
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            io_status <= '0;
        end else begin
            // board I
            io_status.cmode_sel   <= {io_in[0], io_in[2]};
            io_status.ems         <= {io_in[7], io_in[5], io_in[3], io_in[1]};
            io_status.tmp_mon     <= {io_in[6], io_in[4]};
            io_status.ackm_mon    <= io_in[8];
            io_status.sr_err      <= io_in[9];
            io_status.pmode_sel   <= {io_in[12], io_in[10]};
            io_status.en12_pndt   <= io_in[11];
            io_status.acpwr_mon   <= io_in[13];
            io_status.rio_rdy     <= io_in[14];
            io_status.eq_door2_b  <= io_in[15];
            // board II
            io_status.eq_svon_b   <= io_in[0];
            io_status.eq_remote_b <= io_in[1];
            io_status.saf_ems6    <= {io_in[4], io_in[2]};
            io_status.ems12_pndt  <= io_in[5];
            io_status.saf_ems3    <= {io_in[6], io_in[4]};
            io_status.hand_in     <= io_in[14:7];
        end
    end

    // ********************
    // voltage drop monitor
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            irq      <= 1'b0;
            vin_fall <= 1'b0;
        end else begin
            irq      <= voltage_drop;   // level, not edge
            vin_fall <= voltage_drop;
        end
    end

    // ********************
    // output connector
    // low byte is gated by hand_out
    assign io_out[15:13] = cpld_pkg::IO_OUT_TOP;
    assign io_out[12]    = ctrl.ext_disp[0];
    assign io_out[11]    = ctrl.self_son;
    assign io_out[10]    = ctrl.ext_disp[1];
    assign io_out[9]     = ctrl.svo;
    assign io_out[8]     = ctrl.ext_disp[2];
    assign io_out[7]     = ctrl.rb_err      & ctrl.hand_out[7];
    assign io_out[6]     = ctrl.ext_disp[3] & ctrl.hand_out[6];
    assign io_out[5]     = ctrl.rb_rdy      & ctrl.hand_out[5];
    assign io_out[4]     = ctrl.ext_disp[4] & ctrl.hand_out[4];
    assign io_out[3]     = ctrl.crh[1]      & ctrl.hand_out[3];
    assign io_out[2]     = ctrl.ovrun_clr   & ctrl.hand_out[2];
    assign io_out[1]     = ctrl.crh[0]      & ctrl.hand_out[1];
    assign io_out[0]     = ctrl.pndt_svon   & ctrl.hand_out[0];

endmodule

`default_nettype wire

//--- logic/ifc_slave.sv
`default_nettype none

module ifc_slave (
    input  wire                     high_cpld_clk,
    input  wire                     rst_n,
    input  wire cpld_pkg::data_t    ifc_ad_in,
    input  wire cpld_pkg::addr_t    ifc_addr,
    input  wire                     ifc_cs,
    input  wire                     ifc_we_b,
    input  wire                     ifc_oe_b,
    input  wire                     ifc_avd,
    input  wire cpld_pkg::data_t    rdata,
    output cpld_pkg::bus_req_t      bus_req,
    output cpld_pkg::data_t         ifc_ad_out,
    output logic                    ifc_ad_oe
);

    // ********************
    // strobe sampling, bit order {avd, oe, we}
    logic [2:0] strb_s1;
    logic [2:0] strb_s2;
    logic [2:0] strb_fall;

    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            strb_s1 <= '1;      // all strobes idle high
            strb_s2 <= '1;
        end else begin
            strb_s1 <= {ifc_avd, ifc_oe_b, ifc_we_b};
            strb_s2 <= strb_s1;
        end
    end

    assign strb_fall = strb_s2 & ~strb_s1;

    // ********************
    // bus events
    logic            avd_stb;
    logic            rd_q;
    logic            wr_q;
    cpld_pkg::addr_t addr_q;
    cpld_pkg::data_t wdata_in;

    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            avd_stb <= 1'b0;
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            avd_stb <= strb_fall[2];
            rd_q    <= strb_fall[1] & ~ifc_cs;
            wr_q    <= strb_fall[0] & ~ifc_cs;
        end
    end

    // address taken one edge after the avd strobe
    always_ff @(posedge high_cpld_clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else if (avd_stb) begin
            addr_q <= {<<{ifc_addr}};   // bus bit i is reg bit 7-i
        end
    end

    assign wdata_in = {<<{ifc_ad_in}};  // sampled by reg_bank at the wr strobe

    assign bus_req = '{rd: rd_q, wr: wr_q, addr: addr_q, wdata: wdata_in};

    // read path back to the pins
    assign ifc_ad_out = {<<{rdata}};
    assign ifc_ad_oe  = ~ifc_cs & ~ifc_oe_b;

    // master must not drop OE and WE together
    a_rd_wr_excl : assert property (@(posedge high_cpld_clk) disable iff (!rst_n)
        !(rd_q && wr_q));

endmodule

`default_nettype wire

//--- logic/cpld_pkg.sv
`default_nettype none

package cpld_pkg;

    // ********************
    // vector types
    typedef logic [7:0]  addr_t;
    typedef logic [15:0] data_t;
    typedef logic [31:0] cnt_t;

    // ********************
    // bundles between blocks
    typedef struct packed {
        logic  rd;      // one-cycle read strobe
        logic  wr;      // one-cycle write strobe
        addr_t addr;
        data_t wdata;   // already un-reversed
    } bus_req_t;

    typedef struct packed {
        logic [1:0] cmode_sel;
        logic [3:0] ems;
        logic [1:0] tmp_mon;
        logic       ackm_mon;
        logic       sr_err;
        logic [1:0] pmode_sel;
        logic       en12_pndt;
        logic       eq_door2_b;
        logic       acpwr_mon;
        logic       rio_rdy;
        logic       eq_svon_b;
        logic       eq_remote_b;
        logic [1:0] saf_ems6;
        logic       ems12_pndt;
        logic [1:0] saf_ems3;
        logic [7:0] hand_in;
    } io_status_t;

    typedef struct packed {
        logic       pndt_svon;
        logic [1:0] crh;        // 00 or 11 only
        logic       ovrun_clr;
        logic [4:0] ext_disp;
        logic       rb_rdy;
        logic       rb_err;
        logic       svo;
        logic       self_son;
        logic [7:0] hand_out;
    } ctrl_regs_t;

    typedef struct packed {
        logic sel_read;     // bit 2
        logic clear;        // bit 1
        logic enable;       // bit 0
    } cnt_mode_t;

    // ********************
    // register map
    localparam addr_t ADDR_VERSION     = 8'd0;
    localparam addr_t ADDR_CMODE_SEL   = 8'd2;
    localparam addr_t ADDR_EMS         = 8'd3;
    localparam addr_t ADDR_TMP_MON     = 8'd4;
    localparam addr_t ADDR_ACKM_MON    = 8'd5;
    localparam addr_t ADDR_SR_ERR      = 8'd6;
    localparam addr_t ADDR_PMODE_SEL   = 8'd7;
    localparam addr_t ADDR_EN12_PNDT   = 8'd8;
    localparam addr_t ADDR_EQ_DOOR2_B  = 8'd9;
    localparam addr_t ADDR_ACPWR_MON   = 8'd10;
    localparam addr_t ADDR_RIO_RDY     = 8'd11;
    localparam addr_t ADDR_EQ_SVON_B   = 8'd12;
    localparam addr_t ADDR_EQ_REMOTE_B = 8'd13;
    localparam addr_t ADDR_SAF_EMS6    = 8'd14;
    localparam addr_t ADDR_EMS12_PNDT  = 8'd15;
    localparam addr_t ADDR_SAF_EMS3    = 8'd16;
    localparam addr_t ADDR_HAND_IN     = 8'd17;
    localparam addr_t ADDR_PNDT_SVON   = 8'd18;
    localparam addr_t ADDR_CRH         = 8'd19;
    localparam addr_t ADDR_OVRUN_CLR   = 8'd20;
    localparam addr_t ADDR_EXT_DISP    = 8'd21;
    localparam addr_t ADDR_RB_RDY      = 8'd22;
    localparam addr_t ADDR_RB_ERR      = 8'd23;
    localparam addr_t ADDR_SVO         = 8'd24;
    localparam addr_t ADDR_SELF_SON    = 8'd25;
    localparam addr_t ADDR_HAND_OUT    = 8'd26;
    localparam addr_t ADDR_VIN_FALL    = 8'd28;
    localparam addr_t ADDR_CNT_MODE    = 8'd29;
    localparam addr_t ADDR_CNT_B0      = 8'd30;
    localparam addr_t ADDR_CNT_B1      = 8'd31;
    localparam addr_t ADDR_CNT_B2      = 8'd32;
    localparam addr_t ADDR_CNT_B3      = 8'd33;
    localparam addr_t ADDR_TEST        = 8'd34;

    localparam data_t      CPLD_VERSION = 16'h2134;
    localparam data_t      TEST_RESET   = 16'h1234;
    localparam logic [2:0] IO_OUT_TOP   = 3'b011;   // fixed upper pins

endpackage

`default_nettype wire
